// ==== common/cdr_settings.svh ====
`ifndef CDR_SETTINGS_SVH
`define CDR_SETTINGS_SVH

//////////////////// datapath widths

// parallel lanes per adc word
`define NTI 4

// adc code width, two's complement
`define NADC 8

// sliced symbol width
`define NSYM 3

//////////////////// interpolator side

// control word width per interpolator
`define NPI 8

// interpolators driven from one loop
`define NOUT 2

//////////////////// loop filter

// fractional bits below the integer phase
`define PHASE_EST_SHIFT 12

// width of the kp / ki shift fields
`define GAIN_WIDTH 4

`endif

// ==== common/cdr_data_pkg.sv ====
`include "cdr_settings.svh"

package cdr_data_pkg;

    //////////////////// adc side

    typedef logic signed [`NADC-1:0] adc_code_t;
    typedef logic signed [`NSYM-1:0] sym_t;

    // index 0 is the earliest lane in time
    typedef adc_code_t [`NTI-1:0] adc_word_t;
    typedef sym_t [`NTI-1:0] sym_word_t;

    //////////////////// loop side

    // detector output, two guard bits over a code
    typedef logic signed [`NADC+1:0] phase_err_t;

    // phase / freq accumulators and their updates
    typedef logic signed [`NADC+1+`PHASE_EST_SHIFT:0] loop_acc_t;

    //////////////////// interpolator side

    typedef logic [`NPI-1:0] pi_ctl_t;
    typedef pi_ctl_t [`NOUT-1:0] pi_ctl_bus_t;

endpackage

// ==== common/cdr_cfg_pkg.sv ====
`include "cdr_settings.svh"

package cdr_cfg_pkg;

    import cdr_data_pkg::*;

    //////////////////// static loop configuration

    typedef struct packed {
        logic [`GAIN_WIDTH-1:0] kp;   // proportional left shift
        logic [`GAIN_WIDTH-1:0] ki;   // integral left shift
        logic invert;                 // flip detector sign
        logic en_freq_est;            // integral path on
        logic en_clamp;
        loop_acc_t clamp_amt;         // bound on a single phase step
        logic en_ext_pi_ctl;
        pi_ctl_t ext_pi_ctl;          // forced interpolator code
        phase_err_t pd_offset;        // added inside the detector
    } cdr_cfg_t;

    //////////////////// debug read-back

    // one consistent pair, taken in a single cycle
    typedef struct packed {
        phase_err_t phase_est;
        loop_acc_t freq_est;
    } cdr_status_t;

endpackage

// ==== mm_cdr/mm_pd.sv ====
`timescale 1ns/1ps

`include "cdr_settings.svh"

module mm_pd import cdr_data_pkg::*; (
    input  adc_word_t  codes_i,
    input  sym_word_t  syms_i,
    input  phase_err_t pd_offset_i,
    output phase_err_t pd_err_o
);

    // room for 2*(NTI-1) products plus the offset
    localparam int SUM_W   = `NADC + `NSYM + $clog2(2 * `NTI) + 1;
    localparam int ERR_MAX = 2 ** (`NADC + 1) - 1;
    localparam int ERR_MIN = -(2 ** (`NADC + 1));

    logic signed [SUM_W-1:0] pd_sum;
    logic signed [SUM_W-1:0] pd_acc;

    //////////////////// mueller-muller cross products

    always_comb begin
        pd_sum = '0;
        // lane 0 has no earlier neighbour in this word
        for (int k = 1; k < `NTI; k++) begin
            pd_sum = pd_sum + codes_i[k] * syms_i[k-1]
                            - codes_i[k-1] * syms_i[k];
        end
    end

    //////////////////// offset and saturation

    always_comb begin
        pd_acc = pd_sum + pd_offset_i;   // offset sign-extends

        if (pd_acc > ERR_MAX) begin
            pd_err_o = phase_err_t'(ERR_MAX);
        end else if (pd_acc < ERR_MIN) begin
            pd_err_o = phase_err_t'(ERR_MIN);
        end else begin
            pd_err_o = pd_acc[`NADC+1:0];
        end
    end

endmodule

// ==== mm_cdr/mm_cdr.sv ====
`timescale 1ns/1ps

`include "cdr_settings.svh"

module mm_cdr import cdr_data_pkg::*, cdr_cfg_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  cdr_cfg_t    cfg_i,
    input  adc_word_t   codes_i,
    input  sym_word_t   syms_i,
    output pi_ctl_bus_t pi_ctl_o,
    output logic        freq_lvl_cross_o,
    output phase_err_t  phase_est_o,
    output loop_acc_t   freq_upd_o
);

    phase_err_t pd_err;
    phase_err_t phase_err_d;
    phase_err_t phase_err_q;

    loop_acc_t err_ext;           // error widened to accumulator width
    loop_acc_t freq_upd;
    loop_acc_t freq_est_d;
    loop_acc_t freq_est_q;
    loop_acc_t prev_freq_upd_q;
    loop_acc_t phase_upd;
    loop_acc_t phase_upd_clamped;
    loop_acc_t phase_est_d;
    loop_acc_t phase_est_q;
    loop_acc_t clamp_min_q;
    loop_acc_t clamp_max_q;

    logic signed [$bits(loop_acc_t):0] freq_diff;   // one bit over, no wrap
    logic signed [`NPI-1:0] phase_est_out;
    logic freq_lvl_cross;

    //////////////////// phase detector

    mm_pd i_mm_pd (
        .codes_i     (codes_i),
        .syms_i      (syms_i),
        .pd_offset_i (cfg_i.pd_offset),
        .pd_err_o    (pd_err)
    );

    assign phase_err_d = cfg_i.invert ? -pd_err : pd_err;

    //////////////////// clamp bounds

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            clamp_min_q <= '0;
            clamp_max_q <= '0;
        end else begin
            clamp_min_q <= -cfg_i.clamp_amt;
            clamp_max_q <= cfg_i.clamp_amt;
        end
    end

    //////////////////// loop filter

    always_comb begin
        err_ext = phase_err_q;   // sign extension

        // integral path
        freq_upd   = err_ext << cfg_i.ki;
        freq_est_d = freq_est_q + (cfg_i.en_freq_est ? freq_upd : loop_acc_t'(0));
        freq_diff  = freq_upd - prev_freq_upd_q;

        // proportional path plus current frequency
        phase_upd = (err_ext << cfg_i.kp) + freq_est_q;

        if (cfg_i.en_clamp && (phase_upd < clamp_min_q)) begin
            phase_upd_clamped = clamp_min_q;
        end else if (cfg_i.en_clamp && (phase_upd > clamp_max_q)) begin
            phase_upd_clamped = clamp_max_q;
        end else begin
            phase_upd_clamped = phase_upd;
        end

        phase_est_d = phase_est_q + phase_upd_clamped;
    end

    // arithmetic shift by PHASE_EST_SHIFT, low NPI bits kept
    assign phase_est_out = phase_est_q[`PHASE_EST_SHIFT +: `NPI];

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_err_q     <= '0;
            freq_est_q      <= '0;
            prev_freq_upd_q <= '0;
            phase_est_q     <= '0;
        end else begin
            phase_err_q     <= phase_err_d;
            freq_est_q      <= freq_est_d;
            prev_freq_upd_q <= freq_upd;
            if (cfg_i.en_ext_pi_ctl) begin
                // park the integer phase on the forced code
                phase_est_q <= loop_acc_t'(cfg_i.ext_pi_ctl) << `PHASE_EST_SHIFT;
            end else begin
                phase_est_q <= phase_est_d;
            end
        end
    end

    //////////////////// frequency trend

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross <= 1'b0;
        end else begin
            freq_lvl_cross <= (freq_diff > 0);   // update still rising
        end
    end

    //////////////////// outputs

    // override shows at once, no register in the way
    always_comb begin
        for (int i = 0; i < `NOUT; i++) begin
            pi_ctl_o[i] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : pi_ctl_t'(phase_est_out);
        end
    end

    assign freq_lvl_cross_o = freq_lvl_cross;
    assign phase_est_o      = phase_est_out;   // sign-extended for read-back
    assign freq_upd_o       = freq_upd;

endmodule

// ==== hdl/cdr_snapshot.sv ====
`timescale 1ns/1ps

module cdr_snapshot import cdr_data_pkg::*, cdr_cfg_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  logic        sample_req_i,
    input  phase_err_t  phase_est_i,
    input  loop_acc_t   freq_upd_i,
    output cdr_status_t status_o
);

    typedef enum logic [1:0] {
        WAIT,     // request must drop first
        READY,    // armed for a rising request
        SAMPLE    // capture on the next edge
    } snap_state_t;

    snap_state_t state;
    cdr_status_t status_q;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state    <= WAIT;
            status_q <= '0;
        end else begin
            case (state)
                WAIT: begin
                    if (!sample_req_i) state <= READY;
                end
                READY: begin
                    if (sample_req_i) state <= SAMPLE;
                end
                SAMPLE: begin
                    status_q.phase_est <= phase_est_i;
                    status_q.freq_est  <= freq_upd_i;
                    state              <= WAIT;   // held request waits here
                end
                default: state <= WAIT;
            endcase
        end
    end

    assign status_o = status_q;

endmodule

// ==== hdl/cdr_top.sv ====
`timescale 1ns/1ps

module cdr_top import cdr_data_pkg::*, cdr_cfg_pkg::*; (
    input  logic        clk,
    input  logic        ext_rstb,
    input  cdr_cfg_t    cfg_i,
    input  adc_word_t   codes_i,
    input  sym_word_t   syms_i,
    input  logic        sample_req_i,
    output pi_ctl_bus_t pi_ctl_o,
    output logic        freq_lvl_cross_o,
    output cdr_status_t status_o
);

    phase_err_t phase_est;
    loop_acc_t  freq_upd;

    //////////////////// timing loop

    mm_cdr i_mm_cdr (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .cfg_i            (cfg_i),
        .codes_i          (codes_i),
        .syms_i           (syms_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_est_o      (phase_est),
        .freq_upd_o       (freq_upd)
    );

    //////////////////// debug capture

    cdr_snapshot i_cdr_snapshot (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .phase_est_i  (phase_est),
        .freq_upd_i   (freq_upd),
        .status_o     (status_o)
    );

endmodule

// ==== tests/tb_cdr_top.sv ====
`timescale 1ns/1ps

`include "cdr_settings.svh"

module tb_cdr_top import cdr_data_pkg::*, cdr_cfg_pkg::*; ();

    localparam int ERR_MAX = 2 ** (`NADC + 1) - 1;
    localparam int ERR_MIN = -(2 ** (`NADC + 1));
    localparam int ST_WAIT = 0;
    localparam int ST_READY = 1;
    localparam int ST_SAMPLE = 2;

    logic clk;
    logic ext_rstb;
    cdr_cfg_t cfg;
    adc_word_t codes;
    sym_word_t syms;
    logic sample_req;
    pi_ctl_bus_t pi_ctl;
    logic freq_lvl_cross;
    cdr_status_t status;
    integer seed = 32'h329fb1ba;
    string test_name;

    // cycle model state
    phase_err_t m_err_q;
    loop_acc_t m_freq_q;
    loop_acc_t m_prev_upd_q;
    loop_acc_t m_phase_q;
    loop_acc_t m_cmin_q;
    loop_acc_t m_cmax_q;
    logic m_cross_q;
    int m_state;
    cdr_status_t m_status;
    int m_captures;
    logic m_started = 1'b0;   // model state valid from the first edge
    logic m_clamp_used;
    logic m_sat_hi;
    logic m_sat_lo;
    pi_ctl_t last_pi;         // dut code at the previous falling edge

    cdr_top i_cdr_top (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .cfg_i            (cfg),
        .codes_i          (codes),
        .syms_i           (syms),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .status_o         (status)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // mueller-muller sum over neighbouring lanes, saturated
    function automatic phase_err_t pd_model(adc_word_t c, sym_word_t s, phase_err_t off);
        int acc;
        acc = off;
        for (int k = 1; k < `NTI; k++) begin
            acc = acc + int'(c[k]) * int'(s[k-1]) - int'(c[k-1]) * int'(s[k]);
        end
        if (acc > ERR_MAX) acc = ERR_MAX;
        if (acc < ERR_MIN) acc = ERR_MIN;
        return phase_err_t'(acc);
    endfunction

    //////////////////// cycle model

    always @(posedge clk) begin : loop_model
        phase_err_t pd;
        loop_acc_t e_ext;
        loop_acc_t f_upd;
        loop_acc_t p_upd;
        loop_acc_t step;
        logic signed [`NPI-1:0] pe_int;
        if (!ext_rstb) begin
            m_err_q = '0;
            m_freq_q = '0;
            m_prev_upd_q = '0;
            m_phase_q = '0;
            m_cmin_q = '0;
            m_cmax_q = '0;
            m_cross_q = 1'b0;
            m_state = ST_WAIT;
            m_status = '0;
            m_clamp_used = 1'b0;
            m_started = 1'b1;
        end else begin
            pd = pd_model(codes, syms, cfg.pd_offset);
            m_sat_hi = m_sat_hi | (pd == phase_err_t'(ERR_MAX));
            m_sat_lo = m_sat_lo | (pd == phase_err_t'(ERR_MIN));
            e_ext = m_err_q;                        // sign extends
            f_upd = e_ext <<< cfg.ki;
            p_upd = (e_ext <<< cfg.kp) + m_freq_q;
            step = p_upd;
            if (cfg.en_clamp && p_upd < m_cmin_q) step = m_cmin_q;
            if (cfg.en_clamp && p_upd > m_cmax_q) step = m_cmax_q;
            pe_int = m_phase_q >>> `PHASE_EST_SHIFT;
            case (m_state)
                ST_WAIT: m_state = sample_req ? ST_WAIT : ST_READY;
                ST_READY: m_state = sample_req ? ST_SAMPLE : ST_READY;
                default: begin
                    m_status.phase_est = pe_int;
                    m_status.freq_est = f_upd;
                    m_captures++;
                    m_state = ST_WAIT;
                end
            endcase
            m_clamp_used = cfg.en_clamp && !cfg.en_ext_pi_ctl;
            m_cross_q = (f_upd > m_prev_upd_q);     // update rising
            m_prev_upd_q = f_upd;
            if (cfg.en_freq_est) m_freq_q = m_freq_q + f_upd;
            if (cfg.en_ext_pi_ctl) m_phase_q = loop_acc_t'(cfg.ext_pi_ctl) << `PHASE_EST_SHIFT;
            else m_phase_q = m_phase_q + step;
            m_cmin_q = -cfg.clamp_amt;
            m_cmax_q = cfg.clamp_amt;
            m_err_q = cfg.invert ? -pd : pd;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : output_check
        pi_ctl_t exp_pi;
        logic signed [`NPI-1:0] pi_step;
        if (m_started) begin
            exp_pi = cfg.en_ext_pi_ctl ? cfg.ext_pi_ctl
                                       : pi_ctl_t'(m_phase_q >>> `PHASE_EST_SHIFT);
            for (int i = 0; i < `NOUT; i++) begin
                check_value({test_name, " pi_ctl"}, exp_pi, pi_ctl[i]);
            end
            check_value({test_name, " freq_lvl_cross"}, m_cross_q, freq_lvl_cross);
            check_value({test_name, " status"}, m_status, status);
            if (m_clamp_used && !cfg.en_ext_pi_ctl) begin
                // clamp_amt is below one code so the code moves by one at most
                pi_step = pi_ctl[0] - last_pi;
                check_value({test_name, " clamp_step"}, 1, (pi_step >= -1) && (pi_step <= 1));
            end
        end
        last_pi = pi_ctl[0];
    end

    //////////////////// stimulus

    task automatic drive_random();
        adc_word_t c;
        sym_word_t s;
        for (int k = 0; k < `NTI; k++) begin
            c[k] = adc_code_t'($random(seed));
            s[k] = sym_t'($random(seed) % 4);   // -3 .. +3
        end
        codes <= c;
        syms <= s;
    endtask

    // rising ramp of codes, all symbols +-3
    task automatic drive_extreme(input logic up);
        adc_word_t c;
        sym_word_t s;
        for (int k = 0; k < `NTI; k++) begin
            c[k] = adc_code_t'(-128 + 255 * k / (`NTI - 1));
            s[k] = up ? sym_t'(3) : sym_t'(-3);
        end
        codes <= c;
        syms <= s;
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            @(posedge clk);
            drive_random();
        end
    endtask

    task automatic apply_cfg(input cdr_cfg_t c);
        @(posedge clk);
        cfg <= c;
        drive_random();
    endtask

    initial begin : stimulus
        cdr_cfg_t c;
        int n;
        int caps;
        cdr_status_t held;
        test_name = "reset";
        ext_rstb = 1'b0;
        sample_req = 1'b0;
        codes = '0;
        syms = '0;
        c = '0;
        c.kp = 4'd4;
        c.clamp_amt = loop_acc_t'(2048);
        cfg = c;
        m_captures = 0;
        m_sat_hi = 1'b0;
        m_sat_lo = 1'b0;
        repeat (10) @(posedge clk);
        ext_rstb <= 1'b1;

        test_name = "prop_track";
        run_random(300);
        test_name = "integral";
        c.ki = 4'd2;
        c.en_freq_est = 1'b1;
        apply_cfg(c);
        run_random(150);
        c.invert = 1'b1;
        apply_cfg(c);
        run_random(150);
        test_name = "clamp";
        c.en_clamp = 1'b1;
        apply_cfg(c);
        run_random(50);

        test_name = "ext_override";
        c.en_clamp = 1'b0;
        c.en_ext_pi_ctl = 1'b1;
        c.ext_pi_ctl = pi_ctl_t'($random(seed));
        apply_cfg(c);
        @(negedge clk);
        for (int i = 0; i < `NOUT; i++) check_value("ext_same_cycle", c.ext_pi_ctl, pi_ctl[i]);
        run_random(20);
        c.en_ext_pi_ctl = 1'b0;
        apply_cfg(c);
        @(negedge clk);
        check_value("ext_resume", c.ext_pi_ctl, pi_ctl[0]);
        run_random(100);

        test_name = "snapshot";
        repeat (3) begin
            @(posedge clk);
            sample_req <= 1'b0;
            drive_random();
        end
        @(negedge clk);
        caps = m_captures;
        @(posedge clk);
        sample_req <= 1'b1;
        drive_random();
        n = 0;
        while (m_captures == caps) begin
            if (n == 8) begin
                $display("snapshot request was not captured within 8 cycles");
                $display("Testbench failed");
                $fatal(1, "snapshot timeout");
            end
            run_random(1);
            @(negedge clk);
            n++;
        end
        check_value("snap_latency", 2, n);
        check_value("snap_status", m_status, status);
        held = status;
        run_random(10);                         // request still high
        @(negedge clk);
        check_value("snap_hold_count", caps + 1, m_captures);
        check_value("snap_hold_status", held, status);
        @(posedge clk);
        sample_req <= 1'b0;

        test_name = "pd_saturation";
        @(negedge clk);
        m_sat_hi = 1'b0;
        m_sat_lo = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            c.pd_offset = (i % 2) ? phase_err_t'(-100) : phase_err_t'(100);
            cfg <= c;
            drive_extreme(i % 2 == 0);
        end
        run_random(5);
        @(negedge clk);
        check_value("pd_sat_high", 1, m_sat_hi);
        check_value("pd_sat_low", 1, m_sat_lo);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/cdr_data_pkg.sv
common/cdr_cfg_pkg.sv
mm_cdr/mm_pd.sv
mm_cdr/mm_cdr.sv
hdl/cdr_snapshot.sv
hdl/cdr_top.sv
tests/tb_cdr_top.sv

// ==== Bender.yml ====
package:
  name: cdr_top

sources:
  - include_dirs:
      - common
    files:
      - common/cdr_data_pkg.sv
      - common/cdr_cfg_pkg.sv
      - mm_cdr/mm_pd.sv
      - mm_cdr/mm_cdr.sv
      - hdl/cdr_snapshot.sv
      - hdl/cdr_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_cdr_top.sv
